// ==== tb.f ====
verilog/isa_pkg.sv
verilog/cw_pkg.sv
verilog/r_decoder.sv
verilog/id_decoder.sv
verilog/cw_combiner.sv
verilog/decode_unit.sv
dv/tb_clock.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

TOP       ?= tb_top
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  := tb.f
PASS_MSG  := Everything OK

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  build  compile the testbench with Verilator"
	@echo "  test   build and run, pass only if the run reports success"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP, VERILATOR, FLAGS, OBJ_DIR"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import isa_pkg::*;
    import cw_pkg::*;

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [15:0] LFSR_SEED      = 16'd12520;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    logic [INSTR_W-1:0] instr;
    mc_state_e          state;
    logic               cw_credit;
    logic               instr_credit;
    logic               cw_valid;
    logic [CW_W-1:0]    cw;
    logic [K_W-1:0]     k;
    logic               illegal;

    // Fetch and datapath models
    int fetch_credits;
    int dp_credits;
    int pending_credits;
    bit auto_return;
    int words_seen;
    int credit_pulses;
    // Expected {illegal, cw, k} in issue order
    logic [CW_W+K_W:0] exp_q [$];

    logic [15:0] lfsr_q;
    int          err_count;
    int          test_err_start;
    int          tests_run;
    int          tests_passed;
    string       cur_test;
    int          cycle_count = 0;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

    decode_unit u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .state        (state),
        .cw_credit    (cw_credit),
        .instr_credit (instr_credit),
        .cw_valid     (cw_valid),
        .cw           (cw),
        .k            (k),
        .illegal      (illegal)
    );

    // Watchdog with a cycle limit well above the length of all tests
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // ALU select with op in 4:2 and B inversion in bit 1
    function automatic logic [4:0] alu_code(input logic [2:0] op, input logic inv_b);
        return {op, inv_b, 1'b0};
    endfunction

    // Expected {illegal, cw, k} from the decode rules
    function automatic logic [CW_W+K_W:0] ref_decode(input logic [31:0] ins,
                                                     input logic [1:0] st);
        logic [10:0] op11;
        logic [9:0]  op10;
        logic        alu_en;
        logic        alu_bs;
        logic [4:0]  fs;
        logic        rf_b_en;
        logic [4:0]  sa;
        logic [4:0]  sb;
        logic [4:0]  da;
        logic        rf_w;
        logic        ram_en;
        logic        ram_w;
        logic        status_ld;
        logic [1:0]  nxt;
        logic [63:0] kk;
        logic        hit;
        op11      = ins[31:21];
        op10      = ins[31:22];
        alu_en    = 1'b0;
        alu_bs    = 1'b0;
        fs        = 5'b0;
        rf_b_en   = 1'b0;
        sa        = 5'b0;
        sb        = 5'b0;
        da        = 5'b0;
        rf_w      = 1'b0;
        ram_en    = 1'b0;
        ram_w     = 1'b0;
        status_ld = 1'b0;
        nxt       = ST_EXEC0;
        kk        = 64'b0;
        hit       = 1'b1;
        // R-format fields Rm 20:16 shamt 15:10 Rn 9:5 Rd 4:0
        case (op11)
            OP_ADD, OP_ADDS: fs = alu_code(3'b010, 1'b0);
            OP_SUB, OP_SUBS: fs = alu_code(3'b010, 1'b1);
            OP_AND, OP_ANDS: fs = alu_code(3'b000, 1'b0);
            OP_ORR:          fs = alu_code(3'b001, 1'b0);
            OP_EOR:          fs = alu_code(3'b011, 1'b0);
            OP_LSL:          fs = alu_code(3'b100, 1'b0);
            OP_LSR:          fs = alu_code(3'b101, 1'b0);
            default:         hit = 1'b0;
        endcase
        if (hit) begin
            alu_en    = 1'b1;
            rf_w      = 1'b1;
            sa        = ins[9:5];
            sb        = ins[20:16];
            da        = ins[4:0];
            status_ld = (op11 == OP_ADDS) || (op11 == OP_SUBS) || (op11 == OP_ANDS);
            if (op11 == OP_LSL || op11 == OP_LSR) begin
                alu_bs = 1'b1;
                kk     = 64'(ins[15:10]);
            end
        end else begin
            hit = 1'b1;
            case (op10)
                OP_ADDI: fs = alu_code(3'b010, 1'b0);
                OP_SUBI: fs = alu_code(3'b010, 1'b1);
                OP_ANDI: fs = alu_code(3'b000, 1'b0);
                OP_ORRI: fs = alu_code(3'b001, 1'b0);
                OP_EORI: fs = alu_code(3'b011, 1'b0);
                default: hit = 1'b0;
            endcase
            if (hit) begin
                // Immediate in 21:10
                alu_en = 1'b1;
                alu_bs = 1'b1;
                rf_w   = 1'b1;
                sa     = ins[9:5];
                da     = ins[4:0];
                kk     = 64'(ins[21:10]);
            end else if (op11 == OP_LDUR || op11 == OP_STUR) begin
                // Address offset in 20:12 and Rt in 4:0
                hit    = 1'b1;
                alu_bs = 1'b1;
                fs     = alu_code(3'b010, 1'b0);
                sa     = ins[9:5];
                kk     = 64'(ins[20:12]);
                if (op11 == OP_STUR) begin
                    sb      = ins[4:0];
                    rf_b_en = 1'b1;
                    ram_w   = 1'b1;
                end else if (st == ST_EXEC1) begin
                    ram_en = 1'b1;
                    rf_w   = 1'b1;
                    da     = ins[4:0];
                end else begin
                    nxt = ST_EXEC1;
                end
            end
        end
        if (!hit) begin
            return {1'b1, {CW_W{1'b0}}, 64'b0};
        end
        // pc_en and pc_is low with pc_fs 01
        return {1'b0, alu_en, alu_bs, fs, rf_b_en, sa, sb, da, rf_w, ram_en, ram_w,
                1'b0, 2'b01, 1'b0, status_ld, nxt, kk};
    endfunction

    function automatic logic [31:0] make_r(input logic [10:0] op);
        logic [4:0] rm;
        logic [5:0] shamt;
        logic [4:0] rn;
        logic [4:0] rd;
        rm    = 5'(rand_bits(5));
        shamt = 6'(rand_bits(6));
        rn    = 5'(rand_bits(5));
        rd    = 5'(rand_bits(5));
        return {op, rm, shamt, rn, rd};
    endfunction

    function automatic logic [31:0] make_i(input logic [9:0] op);
        logic [11:0] imm;
        logic [4:0]  rn;
        logic [4:0]  rd;
        imm = 12'(rand_bits(12));
        rn  = 5'(rand_bits(5));
        rd  = 5'(rand_bits(5));
        return {op, imm, rn, rd};
    endfunction

    function automatic logic [31:0] make_d(input logic [10:0] op);
        logic [8:0] addr;
        logic [1:0] op2;
        logic [4:0] rn;
        logic [4:0] rt;
        addr = 9'(rand_bits(9));
        op2  = 2'(rand_bits(2));
        rn   = 5'(rand_bits(5));
        rt   = 5'(rand_bits(5));
        return {op, addr, op2, rn, rt};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s, %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        err_count++;
    endtask

    // Datapath model takes one word and returns or holds its credit
    task automatic collect_word();
        logic [CW_W+K_W:0] want;
        words_seen++;
        if (dp_credits == 0) begin
            report_error("a word was delivered without an output credit");
        end else begin
            dp_credits--;
        end
        if (exp_q.size() == 0) begin
            report_error("a word was delivered with none expected");
        end else begin
            want = exp_q.pop_front();
            check_value("illegal", 64'(want[CW_W+K_W]), 64'(illegal));
            check_value("cw", 64'(want[CW_W+K_W-1:K_W]), 64'(cw));
            check_value("k", want[K_W-1:0], k);
        end
        if (auto_return) begin
            cw_credit = 1'b1;
            dp_credits++;
        end else begin
            pending_credits++;
        end
    endtask

    // One cycle that clears pulses and samples outputs on the falling edge
    task automatic tick();
        @(negedge clk);
        instr_valid = 1'b0;
        cw_credit   = 1'b0;
        if (instr_credit !== cw_valid) begin
            report_error("instr_credit and cw_valid were out of step");
        end
        if (instr_credit) begin
            fetch_credits++;
            credit_pulses++;
        end
        if (cw_valid) begin
            collect_word();
        end
    endtask

    // Fetch model sends only while holding a credit
    task automatic send(input logic [31:0] ins, input mc_state_e st);
        tick();
        while (fetch_credits == 0) begin
            tick();
        end
        instr_valid = 1'b1;
        instr       = ins;
        state       = st;
        fetch_credits--;
        exp_q.push_back(ref_decode(ins, st));
    endtask

    task automatic release_credits();
        auto_return = 1'b1;
        while (pending_credits > 0) begin
            tick();
            if (!cw_credit) begin
                cw_credit = 1'b1;
                pending_credits--;
                dp_credits++;
            end
        end
    endtask

    // Wait for every expected word and two idle cycles after it
    task automatic drain();
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (2) tick();
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("test %s: pass", cur_test);
        end else begin
            $display("test %s: fail, %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        check_value("cw_valid", 64'(0), 64'(cw_valid));
        check_value("instr_credit", 64'(0), 64'(instr_credit));
        check_value("illegal", 64'(0), 64'(illegal));
        end_test();
    endtask

    task automatic test_r_format();
        logic [10:0] ops [10];
        int          i;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR,
                OP_ADDS, OP_SUBS, OP_ANDS, OP_LSL, OP_LSR};
        begin_test("r_format");
        for (i = 0; i < 10; i++) begin
            send(make_r(ops[i]), ST_EXEC0);
        end
        drain();
        end_test();
    endtask

    task automatic test_i_format();
        logic [9:0] ops [5];
        int         i;
        ops = '{OP_ADDI, OP_SUBI, OP_ANDI, OP_ORRI, OP_EORI};
        begin_test("i_format");
        for (i = 0; i < 5; i++) begin
            send(make_i(ops[i]), ST_EXEC0);
        end
        drain();
        end_test();
    endtask

    task automatic test_memory();
        logic [31:0] ld;
        begin_test("memory");
        ld = make_d(OP_LDUR);
        // Both microcycles of one load and then a store
        send(ld, ST_EXEC0);
        send(ld, ST_EXEC1);
        send(make_d(OP_STUR), ST_EXEC0);
        drain();
        end_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        send({11'h000, 21'(rand_bits(21))}, ST_EXEC0);
        send({11'h7ff, 21'(rand_bits(21))}, ST_EXEC1);
        // A legal word right after must clear the flag
        send(make_r(OP_ADD), ST_EXEC0);
        drain();
        end_test();
    endtask

    task automatic test_backpressure();
        int words0;
        int pulses0;
        begin_test("backpressure");
        words0      = words_seen;
        pulses0     = credit_pulses;
        auto_return = 1'b0;
        send(make_r(OP_SUBS), ST_EXEC0);
        send(make_i(OP_ORRI), ST_EXEC0);
        send(make_d(OP_LDUR), ST_EXEC0);
        send(make_r(OP_LSR), ST_EXEC0);
        repeat (10) tick();
        // Two words spent the credits and two entries fill the queue
        check_value("words while stalled", 64'(OUT_CREDITS), 64'(words_seen - words0));
        check_value("entries waiting", 64'(IN_DEPTH), 64'(exp_q.size()));
        check_value("fetch credits left", 64'(0), 64'(fetch_credits));
        release_credits();
        send(make_d(OP_STUR), ST_EXEC0);
        send(make_i(OP_EORI), ST_EXEC0);
        drain();
        check_value("words delivered", 64'(6), 64'(words_seen - words0));
        check_value("instr_credit pulses", 64'(words_seen - words0),
                    64'(credit_pulses - pulses0));
        end_test();
    endtask

    task automatic test_latency();
        int words0;
        int n;
        begin_test("latency");
        words0 = words_seen;
        n      = 0;
        send(make_r(OP_EOR), ST_EXEC0);
        while (words_seen == words0) begin
            tick();
            n++;
        end
        // First tick follows the accepting edge and the rest is latency
        check_value("cycles after acceptance", 64'(1), 64'(n - 1));
        drain();
        check_value("words for one instruction", 64'(1), 64'(words_seen - words0));
        end_test();
    endtask

    initial begin
        instr_valid     = 1'b0;
        instr           = '0;
        state           = ST_EXEC0;
        cw_credit       = 1'b0;
        lfsr_q          = LFSR_SEED;
        fetch_credits   = IN_DEPTH;
        dp_credits      = OUT_CREDITS;
        pending_credits = 0;
        auto_return     = 1'b1;
        words_seen      = 0;
        credit_pulses   = 0;
        err_count       = 0;
        tests_run       = 0;
        tests_passed    = 0;
        cur_test        = "none";
        // Reset is unknown until the clock module drives it
        while (rst_n !== 1'b1) begin
            @(negedge clk);
        end
        test_reset();
        test_r_format();
        test_i_format();
        test_memory();
        test_illegal();
        test_backpressure();
        test_latency();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [isa_pkg::INSTR_W-1:0] instr,
    input  isa_pkg::mc_state_e          state,
    input  logic                        cw_credit,
    output logic                        instr_credit,
    output logic                        cw_valid,
    output logic [cw_pkg::CW_W-1:0]     cw,
    output logic [cw_pkg::K_W-1:0]      k,
    output logic                        illegal
);
    import isa_pkg::*;
    import cw_pkg::*;

    // Instruction queue, storage and bookkeeping
    logic [INSTR_W-1:0] q_instr [IN_DEPTH];
    mc_state_e          q_state [IN_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr_nxt;
    logic [PTR_W-1:0]   rd_ptr_nxt;
    logic [CNT_W-1:0]   q_cnt;

    // Credits held toward the datapath
    logic [CNT_W-1:0]   out_cnt;
    logic               issue;

    // Queue head and decoder results
    logic [INSTR_W-1:0] head_instr;
    mc_state_e          head_state;
    logic [CW_W-1:0]    r_cw;
    logic [K_W-1:0]     r_k;
    logic               r_hit;
    logic [CW_W-1:0]    id_cw;
    logic [K_W-1:0]     id_k;
    logic               id_hit;

    // Pop only with an entry waiting and a credit in hand
    assign issue = (q_cnt != '0) && (out_cnt != '0);

    assign head_instr = q_instr[rd_ptr];
    assign head_state = q_state[rd_ptr];

    // Circular pointers
    assign wr_ptr_nxt = (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_nxt = (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    // Fetch only sends with credit, so a push always has room
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_instr[wr_ptr] <= instr;
            q_state[wr_ptr] <= state;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            q_cnt        <= '0;
            out_cnt      <= CNT_W'(OUT_CREDITS);
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (issue) begin
                rd_ptr <= rd_ptr_nxt;
            end
            q_cnt   <= q_cnt + CNT_W'(instr_valid) - CNT_W'(issue);
            // Spent at issue, a cycle before cw_valid shows
            out_cnt <= out_cnt - CNT_W'(issue) + CNT_W'(cw_credit);
            // Freed slot goes back to fetch alongside cw_valid
            instr_credit <= issue;
        end
    end

    r_decoder u_r_dec (
        .instr (head_instr),
        .cw    (r_cw),
        .k     (r_k),
        .hit   (r_hit)
    );

    id_decoder u_id_dec (
        .instr (head_instr),
        .state (head_state),
        .cw    (id_cw),
        .k     (id_k),
        .hit   (id_hit)
    );

    cw_combiner u_comb (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .r_cw     (r_cw),
        .r_k      (r_k),
        .r_hit    (r_hit),
        .id_cw    (id_cw),
        .id_k     (id_k),
        .id_hit   (id_hit),
        .cw_valid (cw_valid),
        .cw       (cw),
        .k        (k),
        .illegal  (illegal)
    );

    // Fetch overran its credits
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> (q_cnt < CNT_W'(IN_DEPTH)))
        else $error("instruction pushed into a full queue");

    // Datapath returned more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (cw_credit && !issue) |-> (out_cnt < CNT_W'(OUT_CREDITS)))
        else $error("output credit count above its initial value");

endmodule

// ==== verilog/cw_combiner.sv ====
`timescale 1ns/1ps

module cw_combiner (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue,
    input  logic [cw_pkg::CW_W-1:0] r_cw,
    input  logic [cw_pkg::K_W-1:0]  r_k,
    input  logic                    r_hit,
    input  logic [cw_pkg::CW_W-1:0] id_cw,
    input  logic [cw_pkg::K_W-1:0]  id_k,
    input  logic                    id_hit,
    output logic                    cw_valid,
    output logic [cw_pkg::CW_W-1:0] cw,
    output logic [cw_pkg::K_W-1:0]  k,
    output logic                    illegal
);
    import cw_pkg::*;

    logic [CW_W-1:0] sel_cw;
    logic [K_W-1:0]  sel_k;
    logic            miss;

    // Pick whichever decoder claimed the opcode
    always_comb begin
        miss = 1'b0;
        if (r_hit) begin
            sel_cw = r_cw;
            sel_k  = r_k;
        end else if (id_hit) begin
            sel_cw = id_cw;
            sel_k  = id_k;
        end else begin
            // Unknown opcode gives a null word
            sel_cw = '0;
            sel_k  = '0;
            miss   = 1'b1;
        end
    end

    // Valid pulse and illegal flag held until the next issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cw_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            cw_valid <= issue;
            if (issue) begin
                illegal <= miss;
            end
        end
    end

    // Output word held until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            cw <= sel_cw;
            k  <= sel_k;
        end
    end

    // Opcode spaces of the two decoders are disjoint
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !(r_hit && id_hit))
        else $error("both decoders claimed the same instruction");

endmodule

// ==== verilog/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  logic [isa_pkg::INSTR_W-1:0] instr,
    input  isa_pkg::mc_state_e          state,
    output logic [cw_pkg::CW_W-1:0]     cw,
    output logic [cw_pkg::K_W-1:0]      k,
    output logic                        hit
);
    import isa_pkg::*;
    import cw_pkg::*;

    logic [OP_I_W-1:0] op_i;
    logic [OP_R_W-1:0] op_d;
    logic [IMM_W-1:0]  imm;
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  rn;
    logic [REG_W-1:0]  rt;
    instr_class_e      cls;
    alu_fn_e           fn;
    logic              is_ld;
    logic              wb;

    // I-format: op[31:22] imm[21:10]
    // D-format: op[31:21] addr[20:12] op2[11:10]
    assign op_i = instr[31:22];
    assign op_d = instr[31:21];
    assign imm  = instr[21:10];
    assign addr = instr[20:12];
    // Rd for I-format, Rt for D-format
    assign rn   = instr[9:5];
    assign rt   = instr[4:0];

    // Classify, 10-bit opcodes first
    always_comb begin
        cls   = CL_I;
        fn    = FN_ADD;
        is_ld = 1'b0;
        case (op_i)
            OP_ADDI: fn = FN_ADD;
            OP_SUBI: fn = FN_SUB;
            OP_ANDI: fn = FN_AND;
            OP_ORRI: fn = FN_OR;
            OP_EORI: fn = FN_XOR;
            default: begin
                // Memory ops, address is Rn plus offset
                case (op_d)
                    OP_LDUR: begin
                        cls   = CL_D;
                        is_ld = 1'b1;
                    end
                    OP_STUR: cls = CL_D;
                    default: cls = CL_NONE;
                endcase
            end
        endcase
    end

    // Second LDUR microcycle writes RAM data back
    assign wb = is_ld && (state == ST_EXEC1);

    assign hit = (cls != CL_NONE);

    always_comb begin
        cw = '0;
        k  = '0;
        case (cls)
            CL_I: begin
                // Rn op imm into Rd, no Rm field in this format
                cw = pack_cw(1'b1, 1'b1, fn, 1'b0, rn, '0, rt,
                             1'b1, 1'b0, 1'b0, 1'b0, ST_EXEC0);
                k  = K_W'(imm);
            end
            CL_D: begin
                k = K_W'(addr);
                if (is_ld) begin
                    // Address cycle, then RAM onto the bus into Rt
                    cw = pack_cw(1'b0, 1'b1, FN_ADD, 1'b0, rn, '0,
                                 wb ? rt : '0, wb, wb, 1'b0, 1'b0,
                                 wb ? ST_EXEC0 : ST_EXEC1);
                end else begin
                    // Rt drives the bus as store data
                    cw = pack_cw(1'b0, 1'b1, FN_ADD, 1'b1, rn, rt, '0,
                                 1'b0, 1'b0, 1'b1, 1'b0, ST_EXEC0);
                end
            end
            default: begin
                cw = '0;
                k  = '0;
            end
        endcase
    end

endmodule

// ==== verilog/r_decoder.sv ====
`timescale 1ns/1ps

module r_decoder (
    input  logic [isa_pkg::INSTR_W-1:0] instr,
    output logic [cw_pkg::CW_W-1:0]     cw,
    output logic [cw_pkg::K_W-1:0]      k,
    output logic                        hit
);
    import isa_pkg::*;
    import cw_pkg::*;

    logic [OP_R_W-1:0]  op;
    logic [REG_W-1:0]   rm;
    logic [SHAMT_W-1:0] shamt;
    logic [REG_W-1:0]   rn;
    logic [REG_W-1:0]   rd;
    instr_class_e       cls;
    alu_fn_e            fn;
    logic               flags;
    logic               shift;

    // R-format field split
    assign {op, rm, shamt, rn, rd} = instr;

    // Opcode to ALU function
    always_comb begin
        cls   = CL_R;
        fn    = FN_ADD;
        flags = 1'b0;
        shift = 1'b0;
        case (op)
            OP_ADD:  fn = FN_ADD;
            OP_SUB:  fn = FN_SUB;
            OP_AND:  fn = FN_AND;
            OP_ORR:  fn = FN_OR;
            OP_EOR:  fn = FN_XOR;
            // Flag-setting forms
            OP_ADDS: begin
                fn    = FN_ADD;
                flags = 1'b1;
            end
            OP_SUBS: begin
                fn    = FN_SUB;
                flags = 1'b1;
            end
            OP_ANDS: begin
                fn    = FN_AND;
                flags = 1'b1;
            end
            // Shift amount comes in through K
            OP_LSL: begin
                fn    = FN_LSL;
                shift = 1'b1;
            end
            OP_LSR: begin
                fn    = FN_LSR;
                shift = 1'b1;
            end
            default: cls = CL_NONE;
        endcase
    end

    assign hit = (cls == CL_R);

    // ALU result to bus, Rn op Rm into Rd
    // B select follows shift so the ALU sees K
    assign cw = hit ? pack_cw(1'b1, shift, fn, 1'b0, rn, rm, rd,
                              1'b1, 1'b0, 1'b0, flags, ST_EXEC0) : '0;

    // Zero-extended shamt, otherwise no constant
    assign k = shift ? K_W'(shamt) : '0;

endmodule

// ==== verilog/cw_pkg.sv ====
package cw_pkg;

    import isa_pkg::*;

    // Control word and constant widths
    localparam int CW_W = 33;
    localparam int K_W  = 64;
    localparam int FS_W = 5;

    // PC+4 select, the only PC function used here
    localparam logic [1:0] PC_FS_INC = 2'b01;

    // ALU function select
    // Bits 4:2 pick the op, bit 1 inverts B, bit 0 inverts A
    typedef enum logic [FS_W-1:0] {
        FN_AND = 5'b00000,
        FN_OR  = 5'b00100,
        FN_ADD = 5'b01000,
        FN_SUB = 5'b01010,
        FN_XOR = 5'b01100,
        FN_LSL = 5'b10000,
        FN_LSR = 5'b10100
    } alu_fn_e;

    // Channel depth and credits
    localparam int IN_DEPTH    = 2;
    localparam int OUT_CREDITS = 2;
    localparam int CNT_W       = 2;
    localparam int PTR_W       = $clog2(IN_DEPTH);

    // Packs the fields in bus order, PC fields fixed
    function automatic logic [CW_W-1:0] pack_cw(
        input logic             alu_en,
        input logic             alu_bs,
        input alu_fn_e          alu_fs,
        input logic             rf_b_en,
        input logic [REG_W-1:0] rf_sa,
        input logic [REG_W-1:0] rf_sb,
        input logic [REG_W-1:0] rf_da,
        input logic             rf_w,
        input logic             ram_en,
        input logic             ram_w,
        input logic             status_ld,
        input mc_state_e        next_state
    );
        // pc_en and pc_is stay low
        return {alu_en, alu_bs, alu_fs, rf_b_en, rf_sa, rf_sb, rf_da, rf_w,
                ram_en, ram_w, 1'b0, PC_FS_INC, 1'b0, status_ld, next_state};
    endfunction

endpackage

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    // Instruction and field widths
    localparam int INSTR_W = 32;
    localparam int OP_R_W  = 11;
    localparam int OP_I_W  = 10;
    localparam int REG_W   = 5;
    localparam int SHAMT_W = 6;
    localparam int IMM_W   = 12;
    localparam int ADDR_W  = 9;

    // R-format opcodes, instr[31:21]
    localparam logic [OP_R_W-1:0] OP_ADD  = 11'b10001011000;
    localparam logic [OP_R_W-1:0] OP_SUB  = 11'b11001011000;
    localparam logic [OP_R_W-1:0] OP_AND  = 11'b10001010000;
    localparam logic [OP_R_W-1:0] OP_ORR  = 11'b10101010000;
    localparam logic [OP_R_W-1:0] OP_EOR  = 11'b11001010000;
    localparam logic [OP_R_W-1:0] OP_ADDS = 11'b10101011000;
    localparam logic [OP_R_W-1:0] OP_SUBS = 11'b11101011000;
    localparam logic [OP_R_W-1:0] OP_ANDS = 11'b11101010000;
    localparam logic [OP_R_W-1:0] OP_LSL  = 11'b11010011011;
    localparam logic [OP_R_W-1:0] OP_LSR  = 11'b11010011010;

    // D-format opcodes, same 11-bit slot
    localparam logic [OP_R_W-1:0] OP_LDUR = 11'b11111000010;
    localparam logic [OP_R_W-1:0] OP_STUR = 11'b11111000000;

    // I-format opcodes, instr[31:22]
    localparam logic [OP_I_W-1:0] OP_ADDI = 10'b1001000100;
    localparam logic [OP_I_W-1:0] OP_SUBI = 10'b1101000100;
    localparam logic [OP_I_W-1:0] OP_ANDI = 10'b1001001000;
    localparam logic [OP_I_W-1:0] OP_ORRI = 10'b1011001000;
    localparam logic [OP_I_W-1:0] OP_EORI = 10'b1101001000;

    // Which decoder family an opcode belongs to
    typedef enum logic [1:0] {
        CL_NONE,
        CL_R,
        CL_I,
        CL_D
    } instr_class_e;

    // Microcycle of a multi-cycle instruction
    typedef enum logic [1:0] {
        ST_EXEC0 = 2'b00,
        ST_EXEC1 = 2'b01
    } mc_state_e;

endpackage
